// File: verilog.f
common/beehive_pkg.sv
source/input_stage.sv
sprite/player_mover.sv
sprite/bee_mover.sv
source/plot_arbiter.sv
source/lives_score.sv
source/beehive_top.sv
verif/beehive_sva.sv
verif/beehive_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the beehive testbench with Verilator, runs it and checks the log for a pass

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module beehive_tb \
	-f verilog.f --Mdir obj_dir -o beehive_sim
then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/beehive_sim > sim.log 2>&1
then
	cat sim.log
	echo "simulation exited with an error status"
	exit 1
fi

cat sim.log

if grep -q -F "*** TEST PASSED ***" sim.log
then
	exit 0
fi

echo "pass message not found in sim.log"
exit 1

// File: verif/beehive_tb.sv
// runs the DUT with tick_cycles 8, so one plot burst every 8 clocks; keys change only between bursts
`timescale 1ns/1ns

module beehive_tb;

	localparam int tick_len = 8;
	localparam int n_random = 300;
	localparam int leg_max = 190;
	localparam int edge_hold = 6;
	localparam int chase_max = 200;
	localparam int max_ticks = n_random + 2 * leg_max + chase_max;
	localparam int watchdog_ns = (max_ticks + 20) * tick_len * 10;
	localparam int seed = 89727;

	// active low patterns for the digits 0 to F
	localparam logic [6:0] seg_table [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	logic               clk;
	logic               resetn;
	logic [3:0]         keys;
	beehive_pkg::plot_t plot;
	logic               plot_valid;
	beehive_pkg::seg_t  hex_lives;
	beehive_pkg::seg_t  hex_score_lo;
	beehive_pkg::seg_t  hex_score_hi;

	// reference model state
	beehive_pkg::plot_t m_player;
	beehive_pkg::plot_t m_bee1;
	beehive_pkg::plot_t m_bee2;
	logic               b1_dx;
	logic               b1_dy;
	logic               b2_dx;
	logic               b2_dy;
	int                 m_deaths;
	logic [7:0]         m_score;

	int         cycle = 0;
	int         last_burst;
	int         errors;
	int         checks;
	int         test_errors;
	int         wraps;
	int         game_overs;
	logic [3:0] walls1;
	logic [3:0] walls2;

	beehive_top #(
		.tick_cycles (tick_len)
	) beehive_top_i (
		.clk          (clk),
		.resetn       (resetn),
		.keys         (keys),
		.plot         (plot),
		.plot_valid   (plot_valid),
		.hex_lives    (hex_lives),
		.hex_score_lo (hex_score_lo),
		.hex_score_hi (hex_score_hi)
	);

	bind beehive_top beehive_sva beehive_sva_i (
		.clk        (clk),
		.resetn     (resetn),
		.plot       (plot),
		.plot_valid (plot_valid),
		.hex_lives  (hex_lives)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got == exp)
		else
		begin
			$display("MISMATCH %s: got 0x%0h expected 0x%0h (cycle %0d)", name, got, exp, cycle);
			errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			$display("ERROR %s (cycle %0d)", what, cycle);
			errors++;
		end
	endtask

	function automatic bit same(input beehive_pkg::plot_t a, input beehive_pkg::plot_t b);
		return (a.x == b.x) && (a.y == b.y);
	endfunction

	// direction for the coming step, reversed when already at the wall ahead
	function automatic logic next_dir(input logic dir, input logic [7:0] pos, input logic [7:0] lim);
		if (dir && pos == lim)
			return 1'b0;
		if (!dir && pos == 8'd0)
			return 1'b1;
		return dir;
	endfunction

	function automatic beehive_pkg::plot_t bee_next(input beehive_pkg::plot_t p, input logic dx,
		input logic dy);
		beehive_pkg::plot_t n;
		n = p;
		n.x = next_dir(dx, p.x, beehive_pkg::x_max) ? p.x + 8'd1 : p.x - 8'd1;
		n.y = next_dir(dy, {1'b0, p.y}, {1'b0, beehive_pkg::y_max}) ? p.y + 7'd1 : p.y - 7'd1;
		return n;
	endfunction

	// active low keys: 0 right, 1 down, 2 up, 3 left
	function automatic beehive_pkg::plot_t step_player(input beehive_pkg::plot_t p,
		input logic [3:0] k);
		beehive_pkg::plot_t n;
		n = p;
		if (!k[0] && k[3] && p.x < beehive_pkg::x_max)
			n.x = p.x + 8'd1;
		else if (!k[3] && k[0] && p.x > 8'd0)
			n.x = p.x - 8'd1;
		if (!k[1] && k[2] && p.y < beehive_pkg::y_max)
			n.y = p.y + 7'd1;
		else if (!k[2] && k[1] && p.y > 7'd0)
			n.y = p.y - 7'd1;
		return n;
	endfunction

	function automatic logic [3:0] walls_of(input beehive_pkg::plot_t p);
		return {p.y == beehive_pkg::y_max, p.y == 7'd0, p.x == beehive_pkg::x_max, p.x == 8'd0};
	endfunction

	// redraw the keys while the player would land on a bee
	function automatic logic [3:0] safe_keys(input logic [3:0] wanted);
		logic [3:0]         k;
		int                 tries;
		beehive_pkg::plot_t n1;
		beehive_pkg::plot_t n2;
		n1 = bee_next(m_bee1, b1_dx, b1_dy);
		n2 = bee_next(m_bee2, b2_dx, b2_dy);
		k = wanted;
		tries = 0;
		while (tries < 32 && (same(step_player(m_player, k), n1) ||
			same(step_player(m_player, k), n2)))
		begin
			k = 4'($urandom);
			tries++;
		end
		return k;
	endfunction

	// head for where bee 1 will be after the next tick
	function automatic logic [3:0] chase_keys();
		beehive_pkg::plot_t t;
		logic [3:0]         k;
		t = bee_next(m_bee1, b1_dx, b1_dy);
		k = 4'hf;
		if (t.x > m_player.x)
			k[0] = 1'b0;
		else if (t.x < m_player.x)
			k[3] = 1'b0;
		if (t.y > m_player.y)
			k[1] = 1'b0;
		else if (t.y < m_player.y)
			k[2] = 1'b0;
		return k;
	endfunction

	task automatic model_step();
		beehive_pkg::plot_t n1;
		beehive_pkg::plot_t n2;
		n1 = bee_next(m_bee1, b1_dx, b1_dy);
		n2 = bee_next(m_bee2, b2_dx, b2_dy);
		b1_dx = next_dir(b1_dx, m_bee1.x, beehive_pkg::x_max);
		b1_dy = next_dir(b1_dy, {1'b0, m_bee1.y}, {1'b0, beehive_pkg::y_max});
		b2_dx = next_dir(b2_dx, m_bee2.x, beehive_pkg::x_max);
		b2_dy = next_dir(b2_dy, {1'b0, m_bee2.y}, {1'b0, beehive_pkg::y_max});
		m_bee1 = n1;
		m_bee2 = n2;
		m_player = step_player(m_player, keys);
		walls1 |= walls_of(m_bee1);
		walls2 |= walls_of(m_bee2);
	endtask

	task automatic bump_score();
		if (m_score == 8'hff)
			wraps++;
		m_score = m_score + 8'd1;
	endtask

	task automatic score_update();
		if (same(m_player, m_bee1) || same(m_player, m_bee2))
		begin
			if (m_deaths == 2)
			begin
				m_deaths = 0;
				m_score = 8'd0;
				game_overs++;
			end
			else
			begin
				m_deaths++;
				bump_score();
			end
		end
		else
			bump_score();
	endtask

	// waits for the next burst, then checks its three plots and the displays
	task automatic check_burst(input bit is_load);
		int waited;
		@(negedge clk);
		waited = 1;
		while (!plot_valid && waited < 3 * tick_len)
		begin
			@(negedge clk);
			waited++;
		end
		expect_true(plot_valid, "no plot burst arrived in time");
		if (is_load)
			expect_true(waited == 2, "load burst did not start two cycles after reset release");
		else
		begin
			check_val("burst spacing", 32'(cycle - last_burst), 32'(tick_len));
			model_step();
		end
		last_burst = cycle;
		score_update();
		check_val("plot player", 32'(plot), 32'(m_player));
		@(negedge clk);
		check_val("plot_valid", 32'(plot_valid), 32'd1);
		check_val("plot bee1", 32'(plot), 32'(m_bee1));
		@(negedge clk);
		check_val("plot_valid", 32'(plot_valid), 32'd1);
		check_val("plot bee2", 32'(plot), 32'(m_bee2));
		check_val("hex_lives", 32'(hex_lives), 32'(seg_table[3 - m_deaths]));
		check_val("hex_score_lo", 32'(hex_score_lo), 32'(seg_table[m_score[3:0]]));
		check_val("hex_score_hi", 32'(hex_score_hi), 32'(seg_table[m_score[7:4]]));
	endtask

	// press towards a corner until the player has sat in it for a few ticks
	task automatic run_leg(input logic [3:0] push, input logic [7:0] tx, input logic [6:0] ty);
		int held;
		int n;
		held = 0;
		n = 0;
		while (held < edge_hold && n < leg_max)
		begin
			keys = safe_keys(push);
			check_burst(1'b0);
			if (m_player.x == tx && m_player.y == ty)
				held++;
			n++;
		end
		expect_true(held == edge_hold, "player was never held in the corner");
	endtask

	task automatic end_test(input string name);
		$display("test %-12s done, %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial
	begin
		int n;
		void'($urandom(seed));
		keys = 4'hf;
		resetn = 1'b1;
		errors = 0;
		checks = 0;
		test_errors = 0;
		wraps = 0;
		game_overs = 0;
		walls1 = 4'h0;
		walls2 = 4'h0;
		last_burst = 0;
		m_player = beehive_pkg::player_start;
		m_bee1 = beehive_pkg::bee1_start;
		m_bee2 = beehive_pkg::bee2_start;
		b1_dx = 1'b1;
		b1_dy = 1'b0;
		b2_dx = 1'b1;
		b2_dy = 1'b0;
		m_deaths = 0;
		m_score = 8'd0;

		repeat (10) @(negedge clk);
		check_val("plot_valid", 32'(plot_valid), 32'd0);
		check_val("hex_lives", 32'(hex_lives), 32'(seg_table[3]));
		check_val("hex_score_lo", 32'(hex_score_lo), 32'(seg_table[0]));
		check_val("hex_score_hi", 32'(hex_score_hi), 32'(seg_table[0]));
		resetn = 1'b0;
		check_burst(1'b1);
		end_test("reset_load");

		for (n = 0; n < n_random; n++)
		begin
			keys = safe_keys(4'($urandom));
			check_burst(1'b0);
		end
		end_test("random_keys");

		// bottom right corner, then top left
		run_leg(4'b1100, beehive_pkg::x_max, beehive_pkg::y_max);
		run_leg(4'b0011, 8'd0, 7'd0);
		end_test("field_edges");

		n = 0;
		while (game_overs == 0 && n < chase_max)
		begin
			keys = chase_keys();
			check_burst(1'b0);
			n++;
		end
		expect_true(game_overs > 0, "player never lost all three lives while chasing bee 1");
		end_test("collisions");

		expect_true(wraps > 0, "score never wrapped past 255");
		expect_true(walls1 == 4'hf, "bee 1 never reached all four walls");
		expect_true(walls2 == 4'hf, "bee 2 never reached all four walls");
		end_test("coverage");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// longest run is every phase at its tick limit
	initial
	begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns without the run finishing", watchdog_ns);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: verif/beehive_sva.sv
// bound into beehive_top; resetn is active high and checks sample on the rising clock edge
`timescale 1ns/1ns

module beehive_sva
(
	input logic               clk,
	input logic               resetn,
	input beehive_pkg::plot_t plot,
	input logic               plot_valid,
	input beehive_pkg::seg_t  hex_lives
);

	// every written pixel lies inside the field
	plot_in_field: assert property (@(posedge clk) disable iff (resetn)
		plot_valid |-> (plot.x <= beehive_pkg::x_max && plot.y <= beehive_pkg::y_max))
	else $error("plot outside the field at x %0d y %0d", plot.x, plot.y);

	// no plots while in reset or just after it
	quiet_in_reset: assert property (@(posedge clk) resetn |=> !plot_valid)
	else $error("plot_valid high during reset");

	// lives display shows 3, 2 or 1
	lives_in_range: assert property (@(posedge clk) disable iff (resetn)
		(hex_lives == 7'h30 || hex_lives == 7'h24 || hex_lives == 7'h79))
	else $error("hex_lives shows an invalid pattern 0x%0h", hex_lives);

endmodule

// File: source/beehive_top.sv
// tick_cycles must be at least 4; plot_valid has no back-pressure, so the sink takes every plot
`timescale 1ns/1ns

module beehive_top
#(
	parameter int tick_cycles = beehive_pkg::tick_cycles_default
)
(
	input  logic               clk,
	input  logic               resetn,
	input  logic [3:0]         keys,
	output beehive_pkg::plot_t plot,
	output logic               plot_valid,
	output beehive_pkg::seg_t  hex_lives,
	output beehive_pkg::seg_t  hex_score_lo,
	output beehive_pkg::seg_t  hex_score_hi
);

	logic [3:0] keys_sync;
	logic       tick;

	beehive_pkg::plot_t player_pos;
	beehive_pkg::plot_t bee1_pos;
	beehive_pkg::plot_t bee2_pos;

	logic player_moved;
	logic bee1_moved;
	logic bee2_moved;

	input_stage #(
		.tick_cycles (tick_cycles)
	) input_stage_i (
		.clk       (clk),
		.resetn    (resetn),
		.keys      (keys),
		.keys_sync (keys_sync),
		.tick      (tick)
	);

	player_mover player_mover_i (
		.clk       (clk),
		.resetn    (resetn),
		.tick      (tick),
		.keys_sync (keys_sync),
		.pos       (player_pos),
		.moved     (player_moved)
	);

	// start parameters carry each bee's colour
	bee_mover #(
		.start (beehive_pkg::bee1_start)
	) bee1 (
		.clk    (clk),
		.resetn (resetn),
		.tick   (tick),
		.pos    (bee1_pos),
		.moved  (bee1_moved)
	);

	bee_mover #(
		.start (beehive_pkg::bee2_start)
	) bee2 (
		.clk    (clk),
		.resetn (resetn),
		.tick   (tick),
		.pos    (bee2_pos),
		.moved  (bee2_moved)
	);

	plot_arbiter plot_arbiter_i (
		.clk          (clk),
		.resetn       (resetn),
		.player       (player_pos),
		.bee1         (bee1_pos),
		.bee2         (bee2_pos),
		.player_moved (player_moved),
		.bee1_moved   (bee1_moved),
		.bee2_moved   (bee2_moved),
		.plot         (plot),
		.plot_valid   (plot_valid)
	);

	lives_score lives_score_i (
		.clk          (clk),
		.resetn       (resetn),
		.player_moved (player_moved),
		.player       (player_pos),
		.bee1         (bee1_pos),
		.bee2         (bee2_pos),
		.hex_lives    (hex_lives),
		.hex_score_lo (hex_score_lo),
		.hex_score_hi (hex_score_hi)
	);

endmodule

// File: source/lives_score.sv
// positions are sampled only while player_moved is high; the score wraps from 255 to 0
`timescale 1ns/1ns

module lives_score
(
	input  logic               clk,
	input  logic               resetn,
	input  logic               player_moved,
	input  beehive_pkg::plot_t player,
	input  beehive_pkg::plot_t bee1,
	input  beehive_pkg::plot_t bee2,
	output beehive_pkg::seg_t  hex_lives,
	output beehive_pkg::seg_t  hex_score_lo,
	output beehive_pkg::seg_t  hex_score_hi
);

	beehive_pkg::lives_t deaths;
	beehive_pkg::score_t score;

	logic       hit_bee1;
	logic       hit_bee2;
	logic       last_life;
	logic [3:0] lives_left;

	// colour is ignored, only the pixel position counts
	assign hit_bee1  = (player.x == bee1.x) && (player.y == bee1.y);
	assign hit_bee2  = (player.x == bee2.x) && (player.y == bee2.y);
	assign last_life = (deaths == beehive_pkg::lives_t'(beehive_pkg::lives_total - 1));

	// checked once per tick on the player's moved strobe
	always_ff @(posedge clk or posedge resetn)
	begin
		if (resetn)
		begin
			deaths <= '0;
			score  <= '0;
		end
		else if (player_moved)
		begin
			if ((hit_bee1 || hit_bee2) && last_life)
			begin
				// game over, start a fresh set of lives
				deaths <= '0;
				score  <= '0;
			end
			else if (hit_bee1 || hit_bee2)
			begin
				deaths <= deaths + 1'b1;
				score  <= score + 1'b1;
			end
			else
				score <= score + 1'b1;
		end
	end

	assign lives_left = 4'(beehive_pkg::lives_total) - 4'(deaths);

	assign hex_lives    = beehive_pkg::seg_encode(lives_left);
	assign hex_score_lo = beehive_pkg::seg_encode(score[3:0]);
	assign hex_score_hi = beehive_pkg::seg_encode(score[7:4]);

endmodule

// File: source/plot_arbiter.sv
// the sink takes one plot every cycle; a sprite must not move again before its plot is issued
`timescale 1ns/1ns

module plot_arbiter
(
	input  logic               clk,
	input  logic               resetn,
	input  beehive_pkg::plot_t player,
	input  beehive_pkg::plot_t bee1,
	input  beehive_pkg::plot_t bee2,
	input  logic               player_moved,
	input  logic               bee1_moved,
	input  logic               bee2_moved,
	output beehive_pkg::plot_t plot,
	output logic               plot_valid
);

	beehive_pkg::plot_t sprite [3];
	beehive_pkg::plot_t held [3];

	logic [2:0] moved;
	logic [2:0] pending;
	logic [2:0] grant;

	// index 0 has the highest priority
	assign sprite[0] = player;
	assign sprite[1] = bee1;
	assign sprite[2] = bee2;
	assign moved     = {bee2_moved, bee1_moved, player_moved};

	// a fresh update wins over the clear of the same slot
	always_ff @(posedge clk or posedge resetn)
	begin
		if (resetn)
			pending <= '0;
		else
			pending <= moved | (pending & ~grant);
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 3; i++)
		begin
			if (moved[i])
				held[i] <= sprite[i];
		end
	end

	always_comb
	begin
		grant = 3'b000;
		plot  = '0;
		if (pending[0])
		begin
			grant = 3'b001;
			plot  = held[0];
		end
		else if (pending[1])
		begin
			grant = 3'b010;
			plot  = held[1];
		end
		else if (pending[2])
		begin
			grant = 3'b100;
			plot  = held[2];
		end
	end

	assign plot_valid = |pending;

endmodule

// File: sprite/bee_mover.sv
// start must lie inside the field; a bee starts heading right and up
`timescale 1ns/1ns

module bee_mover
#(
	parameter beehive_pkg::plot_t start = beehive_pkg::bee1_start
)
(
	input  logic               clk,
	input  logic               resetn,
	input  logic               tick,
	output beehive_pkg::plot_t pos,
	output logic               moved
);

	beehive_pkg::mover_state_t state;

	// 1 means increasing coordinate
	logic dir_x;
	logic dir_y;
	logic flip_x;
	logic flip_y;
	logic up_x;
	logic up_y;

	// at a wall the direction flips and the step goes back into the field
	assign flip_x = dir_x ? (pos.x == beehive_pkg::x_max) : (pos.x == '0);
	assign flip_y = dir_y ? (pos.y == beehive_pkg::y_max) : (pos.y == '0);
	assign up_x   = dir_x ^ flip_x;
	assign up_y   = dir_y ^ flip_y;

	always_ff @(posedge clk or posedge resetn)
	begin
		if (resetn)
		begin
			state <= beehive_pkg::mv_load;
			moved <= 1'b0;
			dir_x <= 1'b1;
			dir_y <= 1'b0;
		end
		else if (state == beehive_pkg::mv_load)
		begin
			state <= beehive_pkg::mv_run;
			moved <= 1'b1;
		end
		else
		begin
			moved <= tick;
			if (tick)
			begin
				dir_x <= up_x;
				dir_y <= up_y;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == beehive_pkg::mv_load)
			pos <= start;
		else if (tick)
		begin
			pos.x <= up_x ? pos.x + 1'b1 : pos.x - 1'b1;
			pos.y <= up_y ? pos.y + 1'b1 : pos.y - 1'b1;
		end
	end

endmodule

// File: sprite/player_mover.sv
// keys_sync must already be synchronous and active low; the position has no reset value
`timescale 1ns/1ns

module player_mover
(
	input  logic               clk,
	input  logic               resetn,
	input  logic               tick,
	input  logic [3:0]         keys_sync,
	output beehive_pkg::plot_t pos,
	output logic               moved
);

	beehive_pkg::mover_state_t state;

	logic go_right;
	logic go_left;
	logic go_down;
	logic go_up;

	// bit 0 right, 1 down, 2 up, 3 left; opposite keys cancel
	assign go_right = !keys_sync[0] && keys_sync[3];
	assign go_left  = !keys_sync[3] && keys_sync[0];
	assign go_down  = !keys_sync[1] && keys_sync[2];
	assign go_up    = !keys_sync[2] && keys_sync[1];

	// load for one cycle, then run forever
	always_ff @(posedge clk or posedge resetn)
	begin
		if (resetn)
		begin
			state <= beehive_pkg::mv_load;
			moved <= 1'b0;
		end
		else if (state == beehive_pkg::mv_load)
		begin
			state <= beehive_pkg::mv_run;
			moved <= 1'b1;
		end
		else
			moved <= tick;
	end

	// one pixel per tick, held at the field edges
	always_ff @(posedge clk)
	begin
		if (state == beehive_pkg::mv_load)
			pos <= beehive_pkg::player_start;
		else if (tick)
		begin
			if (go_right && pos.x != beehive_pkg::x_max)
				pos.x <= pos.x + 1'b1;
			if (go_left && pos.x != '0)
				pos.x <= pos.x - 1'b1;
			if (go_down && pos.y != beehive_pkg::y_max)
				pos.y <= pos.y + 1'b1;
			if (go_up && pos.y != '0)
				pos.y <= pos.y - 1'b1;
		end
	end

endmodule

// File: source/input_stage.sv
// keys are active low and asynchronous; tick_cycles must be at least 4 for the plot bursts
`timescale 1ns/1ns

module input_stage
#(
	parameter int tick_cycles = beehive_pkg::tick_cycles_default
)
(
	input  logic       clk,
	input  logic       resetn,
	input  logic [3:0] keys,
	output logic [3:0] keys_sync,
	output logic       tick
);

	localparam int cnt_w = $clog2(tick_cycles);

	logic [3:0]       keys_meta;
	logic [cnt_w-1:0] count;

	// two-flop synchronizer, released keys read as 1
	always_ff @(posedge clk or posedge resetn)
	begin
		if (resetn)
		begin
			keys_meta <= '1;
			keys_sync <= '1;
		end
		else
		begin
			keys_meta <= keys;
			keys_sync <= keys_meta;
		end
	end

	// tick is registered, so it rises in the cycle after the count hits zero
	always_ff @(posedge clk or posedge resetn)
	begin
		if (resetn)
		begin
			count <= cnt_w'(tick_cycles - 1);
			tick  <= 1'b0;
		end
		else if (count == '0)
		begin
			count <= cnt_w'(tick_cycles - 1);
			tick  <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick  <= 1'b0;
		end
	end

endmodule

// File: common/beehive_pkg.sv
// 160x120 field with inclusive limits and origin at top left; colour is one bit per channel
package beehive_pkg;

	// pixel coordinates and colour
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;
	typedef logic [2:0] colour_t;

	// one pixel write towards the frame buffer
	typedef struct packed
	{
		coord_x_t x;
		coord_y_t y;
		colour_t colour;
	} plot_t;

	// active low, segment 0 in bit 0
	typedef logic [6:0] seg_t;

	// deaths in the current set of lives, 0 to 2
	typedef logic [1:0] lives_t;
	typedef logic [7:0] score_t;

	// sprite FSM, shared by player and bees
	typedef enum logic {mv_load, mv_run} mover_state_t;

	localparam coord_x_t x_max = 8'd159;
	localparam coord_y_t y_max = 7'd119;

	// one tick per second on a 50 MHz board clock
	localparam int tick_cycles_default = 50_000_000;
	localparam int lives_total = 3;

	localparam colour_t player_colour = 3'd7;
	localparam colour_t bee1_colour = 3'd1;
	localparam colour_t bee2_colour = 3'd2;

	localparam plot_t player_start = '{x: 8'd70, y: 7'd70, colour: player_colour};
	localparam plot_t bee1_start = '{x: 8'd10, y: 7'd10, colour: bee1_colour};
	localparam plot_t bee2_start = '{x: 8'd40, y: 7'd40, colour: bee2_colour};

	// hex digit to seven-segment pattern
	function automatic seg_t seg_encode(input logic [3:0] digit);
		seg_t seg;
		case (digit)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h18;
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			// F
			default: seg = 7'h0e;
		endcase
		return seg;
	endfunction

endpackage
